//--- bench/axil_ram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ram_tb;

    localparam int strobe_count    = 64;
    localparam int decode_count    = 8;
    localparam int stream_count    = 64;
    localparam int pause_cycles    = 20;
    localparam int total_txns      = 2 * ram_pkg::ram_words + 2 * strobe_count
                                     + 5 * decode_count + 2 * stream_count + 2;
    localparam int watchdog_cycles = 200 * total_txns + pause_cycles + 1000;

    logic            seq;
    logic            arst_n;
    logic            pause;
    logic            awvalid, awready, wvalid, wready, bvalid, bready;
    logic            arvalid, arready, rvalid, rready;
    axil_pkg::addr_t awaddr, araddr;
    axil_pkg::data_t wdata, rdata;
    axil_pkg::strb_t wstrb;
    axil_pkg::resp_t bresp, rresp;

    integer          seed = 32'h411129a1;
    logic [7:0]      model_mem [ram_pkg::ram_bytes];
    axil_pkg::resp_t exp_bresp [$];
    axil_pkg::resp_t exp_rresp [$];
    axil_pkg::data_t exp_rdata [$];

    tb_clock_gen tb_clock_gen_i (
        .seq    (seq),
        .arst_n (arst_n)
    );

    axil_ram axil_ram_i (.*);

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Byte model of the memory.
    // The decode rule decides before anything is touched.
    function automatic axil_pkg::resp_t model_access(input logic is_write,
            input axil_pkg::addr_t addr, input axil_pkg::data_t wdat,
            input axil_pkg::strb_t strb, output axil_pkg::data_t rdat);
        logic       ok;
        logic [11:0] base;
        ok   = (addr[1:0] == 2'b00) && (addr < axil_pkg::addr_t'(ram_pkg::ram_bytes));
        base = addr[11:0];
        rdat = '0;
        if (!ok) return axil_pkg::resp_decerr;
        for (int b = 0; b < axil_pkg::strb_width; b++) begin
            if (is_write && strb[b]) model_mem[base + 12'(b)] = wdat[8*b +: 8];
            rdat[8*b +: 8] = model_mem[base + 12'(b)];
        end
        return axil_pkg::resp_okay;
    endfunction

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge seq);
            #1;
        end
    endtask

    task automatic send_aw(input axil_pkg::addr_t addr);
        idle_cycles(next_random() & 32'h1);
        awaddr  = addr;
        awvalid = 1'b1;
        @(negedge seq);
        while (!awready) @(negedge seq);
        @(posedge seq);
        #1;
        awvalid = 1'b0;
    endtask

    task automatic send_w(input axil_pkg::data_t data, input axil_pkg::strb_t strb);
        idle_cycles(next_random() & 32'h1);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        @(negedge seq);
        while (!wready) @(negedge seq);
        @(posedge seq);
        #1;
        wvalid = 1'b0;
    endtask

    task automatic send_ar(input axil_pkg::addr_t addr);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge seq);
        while (!arready) @(negedge seq);
        @(posedge seq);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic recv_b();
        idle_cycles(next_random() & 32'h3);
        bready = 1'b1;
        @(negedge seq);
        while (!bvalid) @(negedge seq);
        @(posedge seq);
        #1;
        bready = 1'b0;
    endtask

    task automatic recv_r();
        idle_cycles(next_random() & 32'h3);
        rready = 1'b1;
        @(negedge seq);
        while (!rvalid) @(negedge seq);
        @(posedge seq);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_txn(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             input axil_pkg::strb_t strb);
        axil_pkg::data_t ignored;
        exp_bresp.push_back(model_access(1'b1, addr, data, strb, ignored));
        fork
            send_aw(addr);
            send_w(data, strb);
        join
        recv_b();
    endtask

    task automatic read_txn(input axil_pkg::addr_t addr);
        axil_pkg::data_t data;
        exp_rresp.push_back(model_access(1'b0, addr, '0, '0, data));
        exp_rdata.push_back(data);
        send_ar(addr);
        recv_r();
    endtask

    // Responses are compared on the falling edge before their handshake.
    always @(negedge seq) begin
        if (arst_n && bvalid && bready) begin
            if (exp_bresp.size() == 0) begin
                $display("Write response arrived with no write outstanding");
                abort_run();
            end else begin
                check_value("bresp", 32'(bresp), 32'(exp_bresp.pop_front()));
            end
        end
        if (arst_n && rvalid && rready) begin
            if (exp_rresp.size() == 0) begin
                $display("Read response arrived with no read outstanding");
                abort_run();
            end else begin
                check_value("rresp", 32'(rresp), 32'(exp_rresp.pop_front()));
                check_value("rdata", rdata, exp_rdata.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge seq);
        $display("Timeout after %0d cycles, the DUT stopped answering", watchdog_cycles);
        abort_run();
    end

    initial begin
        axil_pkg::addr_t addr;
        pause   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        @(negedge seq);
        check_value("ready and valid outputs in reset",
                    32'({awready, wready, arready, bvalid, rvalid}), '0);
        wait (arst_n === 1'b1);
        @(negedge seq);
        check_value("ready outputs after reset", 32'({awready, wready, arready}), 32'h7);
        @(posedge seq);
        #1;

        for (int i = 0; i < ram_pkg::ram_words; i++) begin
            write_txn(axil_pkg::addr_t'(4 * i), axil_pkg::data_t'(4 * i), 4'hf);
        end
        for (int i = 0; i < ram_pkg::ram_words; i++) read_txn(axil_pkg::addr_t'(4 * i));

        for (int i = 0; i < strobe_count; i++) begin
            addr = next_random() & 32'h0000_0ffc;
            write_txn(addr, next_random(), axil_pkg::strb_t'(next_random()));
            read_txn(addr);
        end

        // Unaligned, then out of range up to 8192.
        for (int i = 0; i < decode_count; i++) begin
            addr = (next_random() & 32'h0000_0ffc) | axil_pkg::addr_t'(1 + i % 3);
            write_txn(addr, next_random(), 4'hf);
            read_txn(addr);
            read_txn(addr & 32'hffff_fffc);
            addr = 32'h0000_1000 + (next_random() % 32'd1025) * 32'd4;
            write_txn(addr, next_random(), 4'hf);
            read_txn(addr);
        end

        // Writes stay in the lower half and reads in the upper half.
        fork
            for (int i = 0; i < stream_count; i++) begin
                write_txn(next_random() & 32'h0000_07fc, next_random(),
                          axil_pkg::strb_t'(next_random()));
            end
            for (int i = 0; i < stream_count; i++) begin
                read_txn(32'h0000_0800 | (next_random() & 32'h0000_07fc));
            end
        join

        pause = 1'b1;
        fork
            write_txn(32'h0000_0100, next_random(), 4'hf);
            read_txn(32'h0000_0f00);
            begin
                repeat (pause_cycles) begin
                    @(negedge seq);
                    check_value("ready outputs during pause",
                                32'({awready, wready, arready}), '0);
                end
                @(posedge seq);
                #1;
                pause = 1'b0;
            end
        join

        if (exp_bresp.size() != 0 || exp_rresp.size() != 0) begin
            $display("Responses still outstanding at the end of the run");
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic seq,
    output logic arst_n
);

    localparam int half_period = 5;

    initial begin
        seq = 1'b0;
        forever #half_period seq = ~seq;
    end

    // Reset is held for two full clock periods and released on a falling edge.
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge seq);
        @(negedge seq);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the AXI-Lite RAM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module axil_ram_tb \
    -f vlog.f -o axil_ram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/axil_ram_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/axil_pkg.sv
`default_nettype none

package axil_pkg;

    // Bus widths.
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [strb_width-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    // Response codes used on B and R.
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_decerr = 2'b11;

endpackage

`default_nettype wire

//--- source/axil_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ram (
    input  wire logic            seq,
    input  wire logic            arst_n,
    input  wire logic            pause,

    input  wire logic            awvalid,
    output logic                 awready,
    input  wire axil_pkg::addr_t awaddr,

    input  wire logic            wvalid,
    output logic                 wready,
    input  wire axil_pkg::data_t wdata,
    input  wire axil_pkg::strb_t wstrb,

    output logic                 bvalid,
    input  wire logic            bready,
    output axil_pkg::resp_t      bresp,

    input  wire logic            arvalid,
    output logic                 arready,
    input  wire axil_pkg::addr_t araddr,

    output logic                 rvalid,
    input  wire logic            rready,
    output axil_pkg::data_t      rdata,
    output axil_pkg::resp_t      rresp
);

    ram_req_if wr_req ();
    ram_req_if rd_req ();

    axil_write_front axil_write_front_i (
        .seq     (seq),
        .arst_n  (arst_n),
        .pause   (pause),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .mem     (wr_req.requester)
    );

    axil_read_front axil_read_front_i (
        .seq     (seq),
        .arst_n  (arst_n),
        .pause   (pause),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .mem     (rd_req.requester)
    );

    ram_bank ram_bank_i (
        .seq    (seq),
        .arst_n (arst_n),
        .wr     (wr_req.bank),
        .rd     (rd_req.bank)
    );

endmodule

`default_nettype wire

//--- source/axil_read_front.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_front (
    input  wire logic            seq,
    input  wire logic            arst_n,
    input  wire logic            pause,

    input  wire logic            arvalid,
    input  wire axil_pkg::addr_t araddr,
    output logic                 arready,

    output logic                 rvalid,
    output axil_pkg::data_t      rdata,
    output axil_pkg::resp_t      rresp,
    input  wire logic            rready,

    ram_req_if.requester         mem
);

    ram_pkg::front_state_e state;
    logic                  active;
    axil_pkg::addr_t       ar_addr_q;
    axil_pkg::resp_t       rresp_q;
    logic                  ar_fire;

    assign arready = active && (state == ram_pkg::idle) && !pause;
    assign ar_fire = arvalid && arready;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            state   <= ram_pkg::idle;
            rresp_q <= axil_pkg::resp_okay;
        end else begin
            active <= 1'b1;

            unique case (state)
                ram_pkg::idle: begin
                    if (ar_fire) begin
                        if (ram_pkg::addr_valid(araddr)) begin
                            state <= ram_pkg::request;
                        end else begin
                            state   <= ram_pkg::respond;
                            rresp_q <= axil_pkg::resp_decerr;
                        end
                    end
                end
                ram_pkg::request: begin
                    if (mem.gnt) begin
                        state   <= ram_pkg::respond;
                        rresp_q <= axil_pkg::resp_okay;
                    end
                end
                ram_pkg::respond: begin
                    if (rready) state <= ram_pkg::idle;
                end
                default: state <= ram_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (ar_fire) ar_addr_q <= araddr;
    end

    assign mem.req   = (state == ram_pkg::request);
    assign mem.we    = 1'b0;
    assign mem.idx   = ram_pkg::word_index(ar_addr_q);
    assign mem.wdata = '0;
    assign mem.strb  = '0;

    // The bank register holds the word until this side is granted again,
    // which cannot happen before the R handshake.
    assign rvalid = (state == ram_pkg::respond);
    assign rresp  = rresp_q;
    assign rdata  = (rresp_q == axil_pkg::resp_okay) ? mem.rdata : '0;

endmodule

`default_nettype wire

//--- source/axil_write_front.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_front (
    input  wire logic            seq,
    input  wire logic            arst_n,
    input  wire logic            pause,

    input  wire logic            awvalid,
    input  wire axil_pkg::addr_t awaddr,
    output logic                 awready,

    input  wire logic            wvalid,
    input  wire axil_pkg::data_t wdata,
    input  wire axil_pkg::strb_t wstrb,
    output logic                 wready,

    output logic                 bvalid,
    output axil_pkg::resp_t      bresp,
    input  wire logic            bready,

    ram_req_if.requester         mem
);

    ram_pkg::front_state_e state;
    logic                  active;
    logic                  aw_full;
    logic                  w_full;
    axil_pkg::addr_t       aw_addr_q;
    axil_pkg::data_t       w_data_q;
    axil_pkg::strb_t       w_strb_q;
    axil_pkg::resp_t       bresp_q;

    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  pair_ready;
    axil_pkg::addr_t       addr_cur;

    assign awready = active && !aw_full && !pause;
    assign wready  = active && !w_full && !pause;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // Look ahead so that the pair is decoded on the edge it completes.
    assign pair_ready = (aw_full || aw_fire) && (w_full || w_fire);
    assign addr_cur   = aw_full ? aw_addr_q : awaddr;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            state   <= ram_pkg::idle;
            bresp_q <= axil_pkg::resp_okay;
        end else begin
            active <= 1'b1;

            if (b_fire) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
            end else begin
                if (aw_fire) aw_full <= 1'b1;
                if (w_fire) w_full <= 1'b1;
            end

            unique case (state)
                ram_pkg::idle: begin
                    if (pair_ready) begin
                        if (ram_pkg::addr_valid(addr_cur)) begin
                            state <= ram_pkg::request;
                        end else begin
                            state   <= ram_pkg::respond;
                            bresp_q <= axil_pkg::resp_decerr;
                        end
                    end
                end
                ram_pkg::request: begin
                    if (mem.gnt) begin
                        state   <= ram_pkg::respond;
                        bresp_q <= axil_pkg::resp_okay;
                    end
                end
                ram_pkg::respond: begin
                    if (bready) state <= ram_pkg::idle;
                end
                default: state <= ram_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (aw_fire) aw_addr_q <= awaddr;
        if (w_fire) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    assign mem.req   = (state == ram_pkg::request);
    assign mem.we    = 1'b1;
    assign mem.idx   = ram_pkg::word_index(aw_addr_q);
    assign mem.wdata = w_data_q;
    assign mem.strb  = w_strb_q;

    assign bvalid = (state == ram_pkg::respond);
    assign bresp  = bresp_q;

endmodule

`default_nettype wire

//--- source/ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ram_bank (
    input  wire logic seq,
    input  wire logic arst_n,

    ram_req_if.bank   wr,
    ram_req_if.bank   rd
);

    axil_pkg::data_t     mem_q [ram_pkg::ram_words];
    axil_pkg::data_t     rdata_q;
    ram_pkg::arb_side_e  last;
    logic                wr_win;
    logic                rd_win;

    // A lone requester wins at once.
    // Two requesters alternate in round robin.
    assign wr_win = wr.req && (!rd.req || (last == ram_pkg::serve_read));
    assign rd_win = rd.req && !wr_win;

    assign wr.gnt = wr_win;
    assign rd.gnt = rd_win;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            last <= ram_pkg::serve_read;
        end else if (wr_win) begin
            last <= ram_pkg::serve_write;
        end else if (rd_win) begin
            last <= ram_pkg::serve_read;
        end
    end

    // Single storage port.
    always_ff @(posedge seq) begin
        if (wr_win && wr.we) begin
            for (int b = 0; b < axil_pkg::strb_width; b++) begin
                if (wr.strb[b]) begin
                    mem_q[wr.idx][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end else if (rd_win && !rd.we) begin
            rdata_q <= mem_q[rd.idx];
        end
    end

    assign rd.rdata = rdata_q;
    // Writes return nothing.
    assign wr.rdata = '0;

endmodule

`default_nettype wire

//--- source/ram_pkg.sv
`default_nettype none

package ram_pkg;

    localparam int ram_bytes = 4096;
    localparam int ram_words = ram_bytes / axil_pkg::strb_width;
    localparam int byte_bits = $clog2(axil_pkg::strb_width);

    typedef logic [$clog2(ram_words)-1:0] word_idx_t;

    typedef enum logic [1:0] {
        idle,
        request,
        respond
    } front_state_e;

    // Side that the bank served most recently.
    typedef enum logic {
        serve_write,
        serve_read
    } arb_side_e;

    // Aligned and inside the array.
    function automatic logic addr_valid(axil_pkg::addr_t addr);
        return (addr[byte_bits-1:0] == '0) && (addr < axil_pkg::addr_t'(ram_bytes));
    endfunction

    function automatic word_idx_t word_index(axil_pkg::addr_t addr);
        return addr[byte_bits +: $bits(word_idx_t)];
    endfunction

endpackage

`default_nettype wire

//--- source/ram_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_req_if;

    logic                  req;
    logic                  we;
    ram_pkg::word_idx_t    idx;
    axil_pkg::data_t       wdata;
    axil_pkg::strb_t       strb;
    logic                  gnt;
    axil_pkg::data_t       rdata;

    modport requester (
        output req,
        output we,
        output idx,
        output wdata,
        output strb,
        input  gnt,
        input  rdata
    );

    // Grant is combinational and read data follows one cycle after it.
    modport bank (
        input  req,
        input  we,
        input  idx,
        input  wdata,
        input  strb,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

//--- vlog.f
source/axil_pkg.sv
source/ram_pkg.sv
source/ram_req_if.sv
source/axil_write_front.sv
source/axil_read_front.sv
source/ram_bank.sv
source/axil_ram.sv
bench/tb_clock_gen.sv
bench/axil_ram_tb.sv
